//--- design/pm_consts.svh
`ifndef PM_CONSTS_SVH
`define PM_CONSTS_SVH

// end-of-cycle pulse length, in clock cycles
`define PM_KC_TICKS 3

// start-of-cycle pulse length, in clock cycles
`define PM_PC_TICKS 2

// step counter width
`define PM_LK_W 4

// register group counter width
`define PM_LG_W 3

// monostable down counter width
`define PM_TICK_W 4

`endif

//--- design/pm_pkg.sv
`default_nettype none

package pm_pkg;

`include "pm_consts.svh"

	// phase of the end/start of cycle sequencer
	typedef enum logic [1:0] {
		PH_IDLE  = 2'd0,
		PH_ARMED = 2'd1,
		PH_KC    = 2'd2,
		PH_PC    = 2'd3
	} cyc_phase_t;

	// register group counter (LG)
	typedef logic [`PM_LG_W-1:0] lg_val_t;

	// step counter (LK)
	typedef logic [`PM_LK_W-1:0] lk_val_t;

	// premodification counter (MC), saturates at 3
	typedef logic [1:0] mc_val_t;

	// monostable pulse counter
	typedef logic [`PM_TICK_W-1:0] tick_t;

endpackage

`default_nettype wire

//--- design/univib.sv
`timescale 1ns/1ps
`default_nettype none

`include "pm_consts.svh"

module univib #(
	parameter int ticks = 1
) (
	input  logic clk,
	input  logic rst,
	input  logic trig,
	output logic q
);

	import pm_pkg::*;

	localparam tick_t ticks_v = tick_t'(ticks);

	tick_t cnt;

	// a trigger is only taken while idle, no retrigger
	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
		end else if (cnt == '0) begin
			if (trig) begin
				cnt <= ticks_v;
			end
		end else begin
			cnt <= cnt - tick_t'(1);
		end
	end

	// high for exactly ticks cycles after the trigger edge
	assign q = (cnt != '0);

	a_ticks_range: assert property (
		@(posedge clk) disable iff (rst)
		(ticks > 0) && (ticks < (2 ** `PM_TICK_W))
	);

endmodule

`default_nettype wire

//--- design/cycle_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "pm_consts.svh"

module cycle_ctrl #(
	parameter int kc_ticks = `PM_KC_TICKS,
	parameter int pc_ticks = `PM_PC_TICKS
) (
	input  logic __clk,
	input  logic rst,
	input  logic start_,
	input  logic stop_,
	input  logic hlt,
	input  logic wx,
	input  logic cycle_,
	input  logic irq,
	input  logic ekc,
	input  logic mc_0,
	output logic run,
	output logic wait_,
	output logic kc,
	output logic pc,
	output logic sp1,
	output logic si1,
	output logic przerw
);

	import pm_pkg::*;

	logic start_q;
	logic wait_q;
	logic cycle_q;
	logic pr_q;
	logic przerw_q;
	logic kc_d;
	logic trig_kc;
	logic trig_pc;
	cyc_phase_t phase;

	// start flip-flop, stop wins
	always_ff @(posedge __clk) begin
		if (rst || !stop_) begin
			start_q <= 1'b0;
		end else if (!start_) begin
			start_q <= 1'b1;
		end
	end

	// wait flip-flop, set by halt at WX
	always_ff @(posedge __clk) begin
		if (rst || !start_ || si1) begin
			wait_q <= 1'b0;
		end else if (hlt && wx) begin
			wait_q <= 1'b1;
		end
	end

	// single cycle request, dropped once PC begins
	always_ff @(posedge __clk) begin
		if (rst || trig_pc) begin
			cycle_q <= 1'b0;
		end else if (!cycle_) begin
			cycle_q <= 1'b1;
		end
	end

	assign wait_ = ~wait_q;
	assign run = start_q & ~wait_q;

	// KC fires one edge after arming, PC one edge after KC drops
	assign trig_kc = (phase == PH_ARMED);
	assign trig_pc = kc_d & ~kc;

	always_ff @(posedge __clk) begin
		if (rst) begin
			phase <= PH_IDLE;
			kc_d <= 1'b0;
		end else begin
			kc_d <= kc;
			case (phase)
				PH_IDLE:  if (ekc) phase <= PH_ARMED;
				PH_ARMED: phase <= PH_KC;
				PH_KC:    if (trig_pc) phase <= PH_PC;
				PH_PC:    if (!pc) phase <= PH_IDLE;
				default:  phase <= PH_IDLE;
			endcase
		end
	end

	univib #(.ticks(kc_ticks)) u_vib_kc (
		.clk(__clk),
		.rst(rst),
		.trig(trig_kc),
		.q(kc)
	);

	univib #(.ticks(pc_ticks)) u_vib_pc (
		.clk(__clk),
		.rst(rst),
		.trig(trig_pc),
		.q(pc)
	);

	// fetch or interrupt receive, decided as KC rises
	always_ff @(posedge __clk) begin
		if (rst) begin
			pr_q <= 1'b0;
			przerw_q <= 1'b0;
		end else if (trig_kc) begin
			pr_q <= run | cycle_q;
			przerw_q <= irq & mc_0 & (cycle_q | start_q);
		end
	end

	assign przerw = przerw_q;
	assign si1 = pc & przerw_q;
	assign sp1 = pc & pr_q & ~przerw_q;

	a_kc_pc_excl: assert property (@(posedge __clk) disable iff (rst) !(kc && pc));
	a_si1_sp1_excl: assert property (@(posedge __clk) disable iff (rst) !(si1 && sp1));

endmodule

`default_nettype wire

//--- design/mc.sv
`timescale 1ns/1ps
`default_nettype none

module mc (
	input  logic clk,
	input  logic rst,
	input  logic inc,
	input  logic clr,
	output logic mc_3,
	output logic mc_0
);

	import pm_pkg::*;

	localparam mc_val_t mc_max = 2'd3;

	mc_val_t cnt;

	// clear beats increment and the count sticks at 3
	always_ff @(posedge clk) begin
		if (rst || clr) begin
			cnt <= '0;
		end else if (inc && cnt != mc_max) begin
			cnt <= cnt + mc_val_t'(1);
		end
	end

	assign mc_3 = (cnt == mc_max);
	// interrupts are taken only with no premodification pending
	assign mc_0 = (cnt == '0);

endmodule

`default_nettype wire

//--- design/lg.sv
`timescale 1ns/1ps
`default_nettype none

module lg (
	input  logic clk,
	input  logic rst,
	input  logic load,
	input  logic step,
	input  logic ir7,
	input  logic ir8,
	input  logic ir9,
	output logic lga,
	output logic lgb,
	output logic lgc,
	output logic lg_0,
	output logic lg_1,
	output logic lg_2,
	output logic lg_3
);

	import pm_pkg::*;

	lg_val_t val;
	logic [1:0] low;

	// preload from IR 7..9, ir7 is the MSB
	always_ff @(posedge clk) begin
		if (rst) begin
			val <= '0;
		end else if (load) begin
			val <= {ir7, ir8, ir9};
		end else if (step) begin
			// wraps modulo 8
			val <= val + lg_val_t'(1);
		end
	end

	assign lga = val[2];
	assign lgb = val[1];
	assign lgc = val[0];

	// one-hot decode of the two low bits
	assign low = val[1:0];

	always_comb begin
		lg_0 = (low == 2'd0);
		lg_1 = (low == 2'd1);
		lg_2 = (low == 2'd2);
		lg_3 = (low == 2'd3);
	end

endmodule

`default_nettype wire

//--- design/lk.sv
`timescale 1ns/1ps
`default_nettype none

module lk (
	input  logic            clk,
	input  logic            rst,
	input  logic            load,
	input  logic            down,
	input  pm_pkg::lk_val_t lk_in,
	output logic            lk
);

	import pm_pkg::*;

	lk_val_t val;

	// load beats down, down stops at zero
	always_ff @(posedge clk) begin
		if (rst) begin
			val <= '0;
		end else if (load) begin
			val <= lk_in;
		end else if (down && val != '0) begin
			val <= val - lk_val_t'(1);
		end
	end

	// steps left
	assign lk = (val != '0);

	a_lk_no_wrap: assert property (
		@(posedge clk) disable iff (rst)
		(down && !load && val == '0) |=> (val == '0)
	);

endmodule

`default_nettype wire

//--- design/pm.sv
`timescale 1ns/1ps
`default_nettype none

module pm (
	input  logic            __clk,
	input  logic            rst,
	input  logic            start_,
	input  logic            stop_,
	input  logic            cycle_,
	input  logic            hlt,
	input  logic            wx,
	input  logic            irq,
	input  logic            ekc,
	input  logic            premod_inc,
	input  logic            premod_clr,
	input  logic            lg_load,
	input  logic            lg_step,
	input  logic            ir7,
	input  logic            ir8,
	input  logic            ir9,
	input  logic            lk_load,
	input  logic            lk_down,
	input  pm_pkg::lk_val_t lk_in,
	output logic            run,
	output logic            wait_,
	output logic            kc,
	output logic            pc,
	output logic            sp1,
	output logic            si1,
	output logic            przerw,
	output logic            mc_3,
	output logic            mc_0,
	output logic            lga,
	output logic            lgb,
	output logic            lgc,
	output logic            lg_0,
	output logic            lg_1,
	output logic            lg_2,
	output logic            lg_3,
	output logic            lk
);

	import pm_pkg::*;

	// cycle controller gated by the premodification count
	cycle_ctrl u_cycle_ctrl (
		.__clk(__clk),
		.rst(rst),
		.start_(start_),
		.stop_(stop_),
		.hlt(hlt),
		.wx(wx),
		.cycle_(cycle_),
		.irq(irq),
		.ekc(ekc),
		.mc_0(mc_0),
		.run(run),
		.wait_(wait_),
		.kc(kc),
		.pc(pc),
		.sp1(sp1),
		.si1(si1),
		.przerw(przerw)
	);

	mc u_mc (
		.clk(__clk),
		.rst(rst),
		.inc(premod_inc),
		.clr(premod_clr),
		.mc_3(mc_3),
		.mc_0(mc_0)
	);

	lg u_lg (
		.clk(__clk),
		.rst(rst),
		.load(lg_load),
		.step(lg_step),
		.ir7(ir7),
		.ir8(ir8),
		.ir9(ir9),
		.lga(lga),
		.lgb(lgb),
		.lgc(lgc),
		.lg_0(lg_0),
		.lg_1(lg_1),
		.lg_2(lg_2),
		.lg_3(lg_3)
	);

	lk u_lk (
		.clk(__clk),
		.rst(rst),
		.load(lk_load),
		.down(lk_down),
		.lk_in(lk_in),
		.lk(lk)
	);

endmodule

`default_nettype wire

//--- tb/pm_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pm_consts.svh"

module pm_tb;

	import pm_pkg::*;

	// cycle budgets of the reset, start/stop, timing, interrupt, group and step tests
	localparam int budget = 20 + 20 + 40 + 120 + 60 + 60;

	logic clk, rst;
	logic start_, stop_, cycle_, hlt, wx, irq, ekc;
	logic premod_inc, premod_clr, lg_load, lg_step, ir7, ir8, ir9, lk_load, lk_down;
	lk_val_t lk_in;
	logic run, wait_, kc, pc, sp1, si1, przerw, mc_3, mc_0;
	logic lga, lgb, lgc, lg_0, lg_1, lg_2, lg_3, lk;
	logic [31:0] lfsr;
	string test_name;
	int kc_len, pc_len, sp1_n, si1_n, przerw_n;

	pm u_dut (.__clk(clk), .*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		cyc_phase_t ph;
		#(20 * budget * 100);
		ph = u_dut.u_cycle_ctrl.phase;
		$display("Checks failed");
		$fatal(1, "timeout, tests ran past their cycle budget in phase %s", ph.name());
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
	endfunction

	// one LFSR step per bit
	task automatic random_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic give_up(input string why);
		$display("%s: %s", test_name, why);
		$display("Checks failed");
		$fatal(1, "%s could not go on", test_name);
	endtask

	task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("FAIL %s %s expected %0h actual %0h", test_name, what, exp, act);
			$display("Checks failed");
			$fatal(1, "%s stopped on a wrong value", test_name);
		end
	endtask

	// active-low lines get the inverted level
	task automatic set_line(input string sig, input logic on);
		case (sig)
			"start_": start_ <= ~on;
			"stop_": stop_ <= ~on;
			"cycle_": cycle_ <= ~on;
			"start_stop": {start_, stop_} <= {~on, ~on};
			"halt": {hlt, wx} <= {on, on};
			"ekc": ekc <= on;
			"premod_inc": premod_inc <= on;
			"premod_clr": premod_clr <= on;
			"lg_load": lg_load <= on;
			"lg_step": lg_step <= on;
			"lk_load": lk_load <= on;
			"lk_down": lk_down <= on;
			default: give_up({"no such strobe ", sig});
		endcase
	endtask

	// one-clock strobe that returns at the negedge after it was taken
	task automatic strobe(input string sig);
		@(posedge clk);
		set_line(sig, 1'b1);
		@(posedge clk);
		set_line(sig, 1'b0);
		@(negedge clk);
	endtask

	// one end and start of cycle sequence that counts what pc carried
	task automatic run_cycle(input logic extra_ekc);
		int gap;
		gap = 0;
		kc_len = 0;
		pc_len = 0;
		sp1_n = 0;
		si1_n = 0;
		przerw_n = 0;
		strobe("ekc");
		check("kc low at the ekc edge", 0, kc);
		@(negedge clk);
		check("kc one edge after ekc", 1, kc);
		while (kc) begin
			check("sp1 during kc", 0, sp1);
			kc_len++;
			assert (kc_len < 16) else give_up("kc never fell");
			@(posedge clk);
			ekc <= extra_ekc && (kc_len == 1);
			@(negedge clk);
		end
		while (!pc) begin
			check("sp1 between kc and pc", 0, sp1);
			gap++;
			assert (gap < 16) else give_up("pc never rose after kc");
			@(negedge clk);
		end
		while (pc) begin
			pc_len++;
			sp1_n += sp1;
			si1_n += si1;
			przerw_n += przerw;
			assert (pc_len < 16) else give_up("pc never fell");
			@(negedge clk);
		end
	endtask

	task automatic reset_values();
		test_name = "reset_values";
		check("run wait_ kc pc sp1 si1 przerw", 7'b0100000, {run, wait_, kc, pc, sp1, si1, przerw});
		check("mc_3 mc_0", 2'b01, {mc_3, mc_0});
		check("lg and lk", 8'b000_0001_0, {lga, lgb, lgc, lg_3, lg_2, lg_1, lg_0, lk});
	endtask

	task automatic start_stop_halt();
		test_name = "start_stop_halt";
		strobe("start_");
		check("run after start", 1, run);
		strobe("halt");
		check("run wait_ after halt", 2'b00, {run, wait_});
		strobe("start_");
		check("run wait_ after restart", 2'b11, {run, wait_});
		strobe("stop_");
		check("run after stop", 0, run);
		strobe("start_");
		strobe("start_stop");
		// stop has priority
		check("run with start and stop", 0, run);
		strobe("start_");
		check("run before next test", 1, run);
	endtask

	task automatic cycle_timing();
		test_name = "cycle_timing";
		run_cycle(1'b0);
		check("kc length", `PM_KC_TICKS, kc_len);
		check("pc length", `PM_PC_TICKS, pc_len);
		check("sp1 cycles", `PM_PC_TICKS, sp1_n);
		check("si1 cycles", 0, si1_n);
		// a second ekc inside kc is dropped
		run_cycle(1'b1);
		check("kc length with extra ekc", `PM_KC_TICKS, kc_len);
		check("pc length with extra ekc", `PM_PC_TICKS, pc_len);
		repeat (6) begin
			@(negedge clk);
			check("no extra kc", 0, kc);
		end
	endtask

	task automatic interrupts_premod();
		int count;
		test_name = "interrupts_premod";
		strobe("halt");
		@(posedge clk);
		irq <= 1'b1;
		run_cycle(1'b0);
		check("si1 cycles", `PM_PC_TICKS, si1_n);
		check("przerw cycles", `PM_PC_TICKS, przerw_n);
		check("sp1 cycles", 0, sp1_n);
		// si1 ends the halt
		check("run wait_ after si1", 2'b11, {run, wait_});
		strobe("premod_inc");
		count = 1;
		run_cycle(1'b0);
		check("sp1 cycles with premod", `PM_PC_TICKS, sp1_n);
		check("si1 przerw with premod", 0, si1_n + przerw_n);
		repeat (4) begin
			strobe("premod_inc");
			count = (count < 3) ? count + 1 : 3;
			check("mc_3 mc_0", {count == 3, count == 0}, {mc_3, mc_0});
		end
		strobe("premod_clr");
		check("mc_3 mc_0 after clear", 2'b01, {mc_3, mc_0});
		strobe("stop_");
		@(posedge clk);
		irq <= 1'b0;
		strobe("cycle_");
		check("run when stopped", 0, run);
		run_cycle(1'b0);
		check("sp1 cycles single", `PM_PC_TICKS, sp1_n);
		run_cycle(1'b0);
		check("sp1 cycles after single", 0, sp1_n);
	endtask

	task automatic group_counter();
		logic [31:0] v;
		int model;
		test_name = "group_counter";
		repeat (2) begin
			random_bits(3, v);
			@(posedge clk);
			{ir7, ir8, ir9} <= v[2:0];
			strobe("lg_load");
			model = int'(v[2:0]);
			for (int i = 0; i <= 10; i++) begin
				if (i > 0) begin
					strobe("lg_step");
					model = (model + 1) % 8;
				end
				check("lg value", model, {lga, lgb, lgc});
				check("lg decode", 1 << (model % 4), {lg_3, lg_2, lg_1, lg_0});
			end
		end
	endtask

	task automatic step_counter();
		logic [31:0] v;
		int n;
		test_name = "step_counter";
		do begin
			random_bits(4, v);
		end while (v[3:0] == 4'd0);
		n = int'(v[3:0]);
		@(posedge clk);
		lk_in <= lk_val_t'(n);
		strobe("lk_load");
		check("lk after load", 1, lk);
		for (int k = 1; k <= n + 3; k++) begin
			strobe("lk_down");
			check("lk after down", k < n, lk);
		end
		@(posedge clk);
		lk_in <= '0;
		strobe("lk_load");
		check("lk after zero load", 0, lk);
		strobe("lk_down");
		check("lk down from zero", 0, lk);
	endtask

	initial begin
		lfsr = 32'he367_3468;
		rst = 1'b1;
		{start_, stop_, cycle_} = 3'b111;
		{hlt, wx, irq, ekc} = 4'b0000;
		{premod_inc, premod_clr, lg_load, lg_step} = 4'b0000;
		{ir7, ir8, ir9, lk_load, lk_down} = 5'b00000;
		lk_in = '0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		reset_values();
		start_stop_halt();
		cycle_timing();
		interrupts_premod();
		group_counter();
		step_counter();
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+design
design/pm_pkg.sv
design/univib.sv
design/cycle_ctrl.sv
design/mc.sv
design/lg.sv
design/lk.sv
design/pm.sv
tb/pm_tb.sv

//--- Makefile
VERILATOR  ?= verilator
FILELIST   ?= src.f
TB_TOP     ?= pm_tb
RTL_TOP    ?= pm
OBJ_DIR    ?= obj_dir
TIMESCALE  ?= 1ns/1ps
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --timing --timescale $(TIMESCALE) \
		-f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) --timescale $(TIMESCALE) -f $(FILELIST) \
		--top-module $(TB_TOP) -Mdir $(OBJ_DIR) -o V$(TB_TOP)
	./$(OBJ_DIR)/V$(TB_TOP)

clean:
	rm -rf $(OBJ_DIR)
